//--- verilog/fifo_cfg_pkg.sv
// ==========================================================
// FIFO sizes, vector types and the read slot state encoding
// ==========================================================

package fifo_cfg_pkg;

	// Address bits of the memory
	localparam int ADR_WIDTH = 5;

	// Words in the memory, one per address
	localparam int DEPTH = 2 ** ADR_WIDTH;

	// Data bits per word
	localparam int DAT_WIDTH = 32;

	// Read and write pointers, RAM address
	typedef logic [ADR_WIDTH-1:0] adr_t;

	// Used words
	// One bit wider than the address so that DEPTH fits
	typedef logic [ADR_WIDTH:0] cnt_t;

	// Payload word
	typedef logic [DAT_WIDTH-1:0] dat_t;

	// Output slot of the read port
	// SLOT_FULL means the RAM output register holds a word
	// that has not been taken by the consumer yet
	typedef enum logic
	{
		SLOT_EMPTY	= 1'b0,		// Nothing presented
		SLOT_FULL	= 1'b1		// Word presented, valid high
	} slot_state_t;

endpackage

//--- verilog/fifo_bus_pkg.sv
// ==========================================================
// Write beat, read beat and status structs of the FIFO
// ==========================================================

package fifo_bus_pkg;

	// Producer to FIFO
	// Taken on every clock where valid and wr_ready are high
	typedef struct packed
	{
		logic					valid;		// Word offered
		fifo_cfg_pkg::dat_t		data;		// Write data
	} wr_beat_t;

	// FIFO to consumer
	// Data holds while valid is high and rd_ready is low
	typedef struct packed
	{
		logic					valid;		// Word presented
		fifo_cfg_pkg::dat_t		data;		// Read data
	} rd_beat_t;

	// Status of the memory
	// The word sitting in the read slot is not part of used
	typedef struct packed
	{
		fifo_cfg_pkg::cnt_t		used;		// Used words, registered
		logic					empty;		// No word left in RAM
		logic					full;		// Write side closed
	} fifo_status_t;

endpackage

//--- verilog/sdp_ram.sv
// ==========================================================
// Simple dual-port RAM, one clock, registered read output
// ==========================================================

`timescale 1ns/10ps

module sdp_ram
(
	input logic					RST_IN,		// Clock

	// Write port
	input logic					wr_en,
	input fifo_cfg_pkg::adr_t	wr_adr,
	input fifo_cfg_pkg::dat_t	wr_dat,

	// Read port
	input logic					rd_en,
	input fifo_cfg_pkg::adr_t	rd_adr,
	output fifo_cfg_pkg::dat_t	rd_dat
);

// Storage
fifo_cfg_pkg::dat_t mem [fifo_cfg_pkg::DEPTH];

// Write
	always_ff @ (posedge RST_IN)
	begin
		if (wr_en)
			mem[wr_adr] <= wr_dat;
	end

// Read
// Output register only loads on a read enable.
// Without one it keeps the last word, which is what the
// read slot presents while the consumer stalls.
// Same address read and written in one clock gives the old word.
	always_ff @ (posedge RST_IN)
	begin
		if (rd_en)
			rd_dat <= mem[rd_adr];		// One clock latency
	end

endmodule

//--- verilog/fifo_ptr_ctrl.sv
// ==========================================================
// FIFO pointers, clear, empty, used-words count and full
// ==========================================================

`timescale 1ns/10ps

module fifo_ptr_ctrl
#(
	parameter int FULL_MARGIN = 2		// Words kept free to cover the count lag
)
(
	input logic							RST_IN,		// Clock
	input logic							CLK_IN,		// Reset, async active high

	input logic							clr,		// Synchronous clear
	input logic							wr_en,		// Word written this clock
	input logic							fetch,		// Word read from RAM this clock

	output fifo_cfg_pkg::adr_t			wr_adr,
	output fifo_cfg_pkg::adr_t			rd_adr,
	output fifo_bus_pkg::fifo_status_t	status
);

// Signals
fifo_cfg_pkg::adr_t		wr_ptr;
fifo_cfg_pkg::adr_t		rd_ptr;
fifo_cfg_pkg::cnt_t		used_nxt;
fifo_cfg_pkg::cnt_t		used_q;
logic					empty;
logic					full;

// Write pointer
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			wr_ptr <= '0;
		else
		begin
			if (clr)		// Clear wins over a write
				wr_ptr <= '0;
			else if (wr_en)
			begin
				if (wr_ptr == fifo_cfg_pkg::adr_t'(fifo_cfg_pkg::DEPTH - 1))
					wr_ptr <= '0;		// Wrap
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

// Read pointer
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			rd_ptr <= '0;
		else
		begin
			if (clr)
				rd_ptr <= '0;
			else if (fetch)
			begin
				if (rd_ptr == fifo_cfg_pkg::adr_t'(fifo_cfg_pkg::DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

// Pointer distance
	always_comb
	begin
		if (wr_ptr >= rd_ptr)
			used_nxt = fifo_cfg_pkg::cnt_t'(wr_ptr - rd_ptr);
		else		// Write pointer has wrapped
			used_nxt = fifo_cfg_pkg::cnt_t'(fifo_cfg_pkg::DEPTH)
				- fifo_cfg_pkg::cnt_t'(rd_ptr) + fifo_cfg_pkg::cnt_t'(wr_ptr);
	end

// Used words
// Registered for timing, so it trails the pointers by one clock
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			used_q <= '0;
		else
			used_q <= used_nxt;
	end

	assign empty = (wr_ptr == rd_ptr);		// Combinational from the pointers

// Full
// Two back-to-back writes can land before the lagging count shows
// the first one. Closing at DEPTH - FULL_MARGIN keeps the RAM at
// most DEPTH - 1 deep, so equal pointers always mean empty.
	assign full = (used_q >= fifo_cfg_pkg::cnt_t'(fifo_cfg_pkg::DEPTH - FULL_MARGIN));

// Outputs
	assign wr_adr = wr_ptr;
	assign rd_adr = rd_ptr;

	always_comb
	begin
		status.used		= used_q;
		status.empty	= empty;
		status.full		= full;
	end

// Checks
	// Read port only fetches stored words
	ast_no_fetch_empty : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		fetch |-> !empty);

	// Top level holds writes off while full
	ast_no_write_full : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		wr_en |-> !full);

	// Word count never reaches DEPTH, a write never aliases to empty
	ast_no_overflow : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		wr_en && !fetch && !clr |=> !empty);

endmodule

//--- verilog/fifo_read_port.sv
// ==========================================================
// Read port: output slot FSM, RAM fetch and read handshake
// ==========================================================

`timescale 1ns/10ps

module fifo_read_port
(
	input logic							RST_IN,		// Clock
	input logic							CLK_IN,		// Reset, async active high

	input logic							clr,		// Synchronous clear
	input logic							empty,		// RAM holds no word
	input logic							rd_ready,	// Consumer takes the word
	input fifo_cfg_pkg::dat_t			ram_dat,	// RAM output register

	output logic						fetch,		// Read RAM, advance read pointer
	output fifo_bus_pkg::rd_beat_t		rd_beat
);

// Signals
fifo_cfg_pkg::slot_state_t	slot_state;
fifo_cfg_pkg::slot_state_t	slot_nxt;
logic						take;

// Consumer takes the presented word this clock
	assign take = (slot_state == fifo_cfg_pkg::SLOT_FULL) && rd_ready;

// Fetch
// Refill when the slot is free or is being emptied right now,
// which keeps one word per clock under a steady rd_ready
	assign fetch = !clr && !empty
		&& ((slot_state == fifo_cfg_pkg::SLOT_EMPTY) || take);

// Next slot state
	always_comb
	begin
		slot_nxt = slot_state;

		case (slot_state)
			fifo_cfg_pkg::SLOT_EMPTY :
			begin
				if (fetch)
					slot_nxt = fifo_cfg_pkg::SLOT_FULL;		// RAM word lands next clock
			end

			fifo_cfg_pkg::SLOT_FULL :
			begin
				if (take && !fetch)
					slot_nxt = fifo_cfg_pkg::SLOT_EMPTY;
			end

			default :
				slot_nxt = fifo_cfg_pkg::SLOT_EMPTY;
		endcase

		// Clear drops the presented word too
		if (clr)
			slot_nxt = fifo_cfg_pkg::SLOT_EMPTY;
	end

// Slot state
	always_ff @ (posedge RST_IN, posedge CLK_IN)
	begin
		if (CLK_IN)
			slot_state <= fifo_cfg_pkg::SLOT_EMPTY;
		else
			slot_state <= slot_nxt;
	end

// Outputs
// Data comes straight from the RAM register, held by its read enable
	always_comb
	begin
		rd_beat.valid	= (slot_state == fifo_cfg_pkg::SLOT_FULL);
		rd_beat.data	= ram_dat;
	end

// Checks
	// Stalled word stays presented and unchanged until taken
	ast_hold_stall : assert property (@(posedge RST_IN) disable iff (CLK_IN)
		rd_beat.valid && !rd_ready && !clr |=> rd_beat.valid && $stable(rd_beat.data));

endmodule

//--- verilog/sc_fifo_top.sv
// ==========================================================
// Single-clock FWFT FIFO top: RAM, pointer control, read port
// ==========================================================

`timescale 1ns/10ps

module sc_fifo_top
#(
	parameter int FULL_MARGIN = 2		// Passed to the pointer control
)
(
	input logic							RST_IN,		// Clock
	input logic							CLK_IN,		// Reset, async active high
	input logic							clr,		// Synchronous clear

	// Write side
	input fifo_bus_pkg::wr_beat_t		wr_beat,
	output logic						wr_ready,

	// Read side
	output fifo_bus_pkg::rd_beat_t		rd_beat,
	input logic							rd_ready,

	output fifo_bus_pkg::fifo_status_t	status
);

// Signals
logic					wr_en;
logic					fetch;
fifo_cfg_pkg::adr_t		wr_adr;
fifo_cfg_pkg::adr_t		rd_adr;
fifo_cfg_pkg::dat_t		ram_dat;

// Write handshake
	assign wr_ready	= !status.full;
	assign wr_en	= wr_beat.valid && !status.full;

// Memory
	sdp_ram RAM_INST
	(
		.RST_IN		(RST_IN),
		.wr_en		(wr_en),
		.wr_adr		(wr_adr),
		.wr_dat		(wr_beat.data),
		.rd_en		(fetch),		// Read only on a fetch
		.rd_adr		(rd_adr),
		.rd_dat		(ram_dat)
	);

// Pointers and status
	fifo_ptr_ctrl
	#(
		.FULL_MARGIN	(FULL_MARGIN)
	)
	PTR_INST
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.clr		(clr),
		.wr_en		(wr_en),
		.fetch		(fetch),
		.wr_adr		(wr_adr),
		.rd_adr		(rd_adr),
		.status		(status)
	);

// Output slot
	fifo_read_port RD_INST
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.clr		(clr),
		.empty		(status.empty),
		.rd_ready	(rd_ready),
		.ram_dat	(ram_dat),
		.fetch		(fetch),
		.rd_beat	(rd_beat)
	);

endmodule

//--- verification/sc_fifo_tb_checks.svh
// ==========================================================
// Testbench check task, LFSR stepping and error counters
// ==========================================================

`ifndef SC_FIFO_TB_CHECKS_SVH
`define SC_FIFO_TB_CHECKS_SVH

int				check_count = 0;
int				error_count = 0;
logic [31:0]	lfsr_state = 32'he127_bb0a;		// Seed

// Compare one value, report a mismatch
task automatic compare
(
	input string		test,
	input string		what,
	input logic [63:0]	expected,
	input logic [63:0]	actual
);
	check_count++;
	if (expected !== actual)
	begin
		error_count++;
		$display("** Error %0s: %0s expected %0h, actual %0h", test, what, expected, actual);
	end
endtask

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic fb;
	fb = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], fb};
endfunction

// One LFSR step per bit taken
// Newest bit lands in the LSB
task automatic draw_bits(input int n, output logic [31:0] bits);
	bits = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr_state = lfsr_next(lfsr_state);
		bits = {bits[30:0], lfsr_state[0]};
	end
endtask

`endif

//--- verification/sc_fifo_tb.sv
// ==========================================================
// FIFO testbench: pattern reader, reference queue, watchdog
// ==========================================================

`timescale 1ns/10ps

module sc_fifo_tb;

	localparam int		FULL_MARGIN = 2;
	localparam int		RESET_CLOCKS = 16;
	localparam int		FIRST_WORD_LATENCY = 2;		// Write driven to read valid
	localparam int		IDLE_CLOCKS = 3;
	localparam int		CLOCKS_PER_LINE = 40;
	localparam string	PATTERN_FILE = "verification/sc_fifo_patterns.txt";

	logic							RST_IN;		// Clock
	logic							CLK_IN;		// Reset
	logic							clr;
	fifo_bus_pkg::wr_beat_t			wr_beat;
	logic							wr_ready;
	fifo_bus_pkg::rd_beat_t			rd_beat;
	logic							rd_ready;
	fifo_bus_pkg::fifo_status_t		status;

	fifo_cfg_pkg::dat_t		model[$];		// Written but not yet read
	fifo_cfg_pkg::dat_t		next_word;
	logic					word_held;		// next_word still waits for wr_ready
	int						clk_count;
	logic					lat_pending;
	int						lat_start;
	logic [7:0]				op_list[$];
	int						operand_list[$];
	string					name_list[$];
	string					test_name;
	int						watchdog_clocks;
	logic					limit_ready;

`include "sc_fifo_tb_checks.svh"

	sc_fifo_top #(.FULL_MARGIN(FULL_MARGIN)) UUT
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.clr		(clr),
		.wr_beat	(wr_beat),
		.wr_ready	(wr_ready),
		.rd_beat	(rd_beat),
		.rd_ready	(rd_ready),
		.status		(status)
	);

	always
	begin
		#5 RST_IN = ~RST_IN;
	end

	// Op code, operand and test name per line
	// Lines starting with '#' are skipped
	task automatic load_patterns();
		int					fd;
		int					code;
		int					fields;
		int					operand;
		logic [8*128-1:0]	line_buf;
		logic [8*8-1:0]		op_tok;
		logic [8*32-1:0]	name_tok;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file %0s", PATTERN_FILE);
			error_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line_buf = '0;
				op_tok = '0;
				name_tok = '0;
				operand = 0;
				fields = 0;
				code = $fgets(line_buf, fd);
				if (code > 0)
					fields = $sscanf(line_buf, "%s %d %s", op_tok, operand, name_tok);
				if (fields == 3 && op_tok[7:0] != "#")
				begin
					op_list.push_back(op_tok[7:0]);
					operand_list.push_back(operand);
					name_list.push_back(string'(name_tok));
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic prepare_word();
		if (!word_held)
		begin
			draw_bits(fifo_cfg_pkg::DAT_WIDTH, next_word);
			word_held = 1'b1;
		end
	endtask

	// Samples the outputs, drives the inputs 1 ns after the edge and updates the model
	task automatic run_clock(input logic wv, input logic rr, input logic cl,
		output logic wr_fire, output logic rd_fire);
		logic					valid_now;
		logic					ready_now;
		logic					was_empty;
		fifo_cfg_pkg::dat_t		dat_now;
		fifo_cfg_pkg::dat_t		oldest;
		valid_now = rd_beat.valid;
		ready_now = wr_ready;
		dat_now = rd_beat.data;
		was_empty = (model.size() == 0);
		if (lat_pending && valid_now)
		begin
			compare(test_name, "clocks to read valid", 64'(FIRST_WORD_LATENCY),
				64'(clk_count - lat_start));
			lat_pending = 1'b0;
		end
		else if (lat_pending && (clk_count - lat_start >= FIRST_WORD_LATENCY))
		begin
			compare(test_name, "read valid at latency", 64'(1), 64'(valid_now));
			lat_pending = 1'b0;
		end
		wr_beat.valid = wv;
		wr_beat.data = next_word;
		rd_ready = rr;
		clr = cl;
		wr_fire = wv && ready_now;
		rd_fire = valid_now && rr;
		if (rd_fire && was_empty)
		begin
			$display("Read valid in %0s with no word left to read", test_name);
			error_count++;
		end
		else if (rd_fire)
		begin
			oldest = model.pop_front();
			compare(test_name, "read data", 64'(oldest), 64'(dat_now));
		end
		if (wr_fire)
		begin
			if (was_empty && !lat_pending)		// Word into a fully empty FIFO
			begin
				lat_pending = 1'b1;
				lat_start = clk_count;
			end
			model.push_back(next_word);
			word_held = 1'b0;
		end
		if (cl)
		begin
			model.delete();
			lat_pending = 1'b0;
		end
		@(posedge RST_IN);
		#1;
		clk_count++;
	endtask

	task automatic write_words(input int n);
		logic wf;
		logic rf;
		for (int i = 0; i < n; i++)
		begin
			prepare_word();
			run_clock(1'b1, 1'b0, 1'b0, wf, rf);
		end
	endtask

	// Ready held high with no gap once the first word is taken
	task automatic read_words(input int n);
		int		taken;
		logic	wf;
		logic	rf;
		taken = 0;
		while (taken < n)
		begin
			if (taken > 0 && model.size() > 0)
				compare(test_name, "read valid while streaming", 64'(1), 64'(rd_beat.valid));
			run_clock(1'b0, 1'b1, 1'b0, wf, rf);
			if (rf)
				taken++;
		end
	endtask

	task automatic random_mix(input int n);
		logic [31:0]	wv;
		logic [31:0]	rr;
		logic			wf;
		logic			rf;
		for (int i = 0; i < n; i++)
		begin
			draw_bits(1, wv);
			draw_bits(1, rr);
			prepare_word();
			run_clock(wv[0], rr[0], 1'b0, wf, rf);
		end
	endtask

	task automatic clear_fifo();
		logic wf;
		logic rf;
		run_clock(1'b0, 1'b0, 1'b1, wf, rf);
		compare(test_name, "read valid after clear", 64'(0), 64'(rd_beat.valid));
	endtask

	// Idle, then compare the status with the expected used words
	task automatic check_status(input int n);
		logic wf;
		logic rf;
		logic full_exp;
		repeat (IDLE_CLOCKS)
			run_clock(1'b0, 1'b0, 1'b0, wf, rf);
		full_exp = (n >= fifo_cfg_pkg::DEPTH - FULL_MARGIN);
		compare(test_name, "used words", 64'(n), 64'(status.used));
		compare(test_name, "empty", 64'(n == 0), 64'(status.empty));
		compare(test_name, "full", 64'(full_exp), 64'(status.full));
		compare(test_name, "wr_ready", 64'(!full_exp), 64'(wr_ready));
		compare(test_name, "read valid", 64'(model.size() > 0), 64'(rd_beat.valid));
		compare(test_name, "words held", 64'(model.size()),
			64'(status.used) + 64'(rd_beat.valid));
	endtask

	task automatic run_step(input logic [7:0] op, input int n);
		case (op)
			"W" : write_words(n);
			"R" : read_words((n == 0) ? model.size() : n);		// R 0 drains
			"B" : random_mix(n);
			"C" : clear_fifo();
			"S" : check_status(n);
			default :
			begin
				$display("Unknown op code %c in %0s", op, test_name);
				error_count++;
			end
		endcase
	endtask

	initial
	begin
		RST_IN = 1'b0;
		CLK_IN = 1'b1;
		clr = 1'b0;
		wr_beat = '0;
		rd_ready = 1'b0;
		next_word = '0;
		word_held = 1'b0;
		clk_count = 0;
		lat_pending = 1'b0;
		lat_start = 0;
		limit_ready = 1'b0;
		load_patterns();
		watchdog_clocks = RESET_CLOCKS + CLOCKS_PER_LINE * op_list.size();
		foreach (operand_list[i])
			watchdog_clocks += operand_list[i];
		limit_ready = 1'b1;
		repeat (RESET_CLOCKS) @(posedge RST_IN);
		#1 CLK_IN = 1'b0;
		foreach (op_list[i])
		begin
			test_name = name_list[i];
			run_step(op_list[i], operand_list[i]);
		end
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (limit_ready);
		repeat (watchdog_clocks) @(posedge RST_IN);
		$display("Timeout: the patterns did not finish within %0d clocks", watchdog_clocks);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- verification/sc_fifo_patterns.txt
# op operand test_name
# W n write, R n read (R 0 reads all), B n random clocks, C clear, S n idle and expect n used
S 0 reset_state
W 1 first_word_latency
R 1 first_word_read
S 0 first_word_empty
W 10 ten_words_write
S 9 ten_words_status
R 10 ten_words_read
S 0 ten_words_empty
W 40 fill_write
S 31 fill_status
R 32 fill_drain
S 0 fill_empty
W 5 clear_prefill
C 0 clear_midway
S 0 clear_status
W 3 clear_write_again
R 3 clear_read_again
S 0 clear_empty
B 200 random_short
R 0 random_short_drain
S 0 random_short_empty
W 40 refill_write
S 31 refill_status
C 0 clear_when_full
S 0 clear_full_status
W 2 post_full_write
R 2 post_full_read
B 400 random_long
R 0 random_long_drain
S 0 random_long_empty
W 20 stream_write
R 20 stream_read
S 0 stream_empty

//--- project.f
+incdir+verification
verilog/fifo_cfg_pkg.sv
verilog/fifo_bus_pkg.sv
verilog/sdp_ram.sv
verilog/fifo_ptr_ctrl.sv
verilog/fifo_read_port.sv
verilog/sc_fifo_top.sv
verification/sc_fifo_tb.sv

//--- Makefile
# Verilator build and run of the FIFO testbench

TOP       ?= sc_fifo_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All checks passed

.PHONY: all compile run check clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

check:
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
